//--- common/forth_config.svh
/*
 * Forth core configuration
 * Sizes of the cell, stacks, ROM, dictionary and queues,
 * and the serial bit divider
 */
`ifndef FORTH_CONFIG_SVH
`define FORTH_CONFIG_SVH

// Data path
`define CELL_WIDTH 32
`define DSTACK_DEPTH 16

// Program and dictionary storage
`define ROM_DEPTH 64
`define DICT_DEPTH 32
`define QUEUE_DEPTH 16

// Clocks per serial bit, 8 for simulation
// On the board use clock frequency / 19200, e.g. 2604 at 50 MHz
`define UART_BIT_DIV 8

`endif

//--- common/forth_pkg.sv
/*
 * Forth core types
 * Vector types for cells, ROM addresses, stack pointers, characters
 * and LEDs, plus the opcode set of the inner interpreter
 */
`include "forth_config.svh"

package forth_pkg;

	// One stack or ROM cell
	typedef logic [`CELL_WIDTH-1:0] cell_t;
	// Boot ROM address, also used as execution token
	typedef logic [$clog2(`ROM_DEPTH)-1:0] rom_addr_t;
	typedef logic [$clog2(`DSTACK_DEPTH)-1:0] dptr_t;
	typedef logic [7:0] byte_t;
	// Red, blue, green from MSB down
	typedef logic [2:0] led_t;

	// Opcodes live in the low bits of a ROM cell
	typedef enum logic [3:0] {
		op_lit,
		op_branch,
		op_0branch,
		op_dup,
		op_drop,
		op_plus,
		op_minus,
		op_negate,
		op_zero_equal,
		op_zero_less_than,
		op_emit,
		op_io_led,
		op_execute,
		op_number
	} op_e;

endpackage

//--- forth_proc.f
+incdir+common
common/forth_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
verilog/outer_interp.sv
verilog/inner_interp.sv
verilog/forth_proc.sv
verif/forth_proc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the forth_proc testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module forth_proc_tb \
	-f forth_proc.f --Mdir obj_dir -o forth_proc_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/forth_proc_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "test passed" sim.log; then
	exit 0
fi
exit 1

//--- uart/uart_rx.sv
/*
 * UART receiver
 * 8N1 frames at a fixed bit divider, sampled mid-bit, LSB first.
 * A received byte is held as valid until it is taken.
 */
`timescale 1ns/1ns
`include "forth_config.svh"

module uart_rx import forth_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  rx,
	output logic  rx_valid,
	output byte_t rx_data,
	input  logic  rx_take
);

	localparam int div_w = $clog2(`UART_BIT_DIV);
	localparam logic [div_w-1:0] div_last = div_w'(`UART_BIT_DIV - 1);
	localparam logic [div_w-1:0] div_half = div_w'(`UART_BIT_DIV / 2);

	logic [1:0] rx_sync;
	logic busy;
	logic [div_w-1:0] div_cnt;
	// 0 start, 1..8 data, 9 stop
	logic [3:0] bit_cnt;
	byte_t shift_reg;

	assign rx_data = shift_reg;

	always_ff @(posedge clk) begin
		if (!reset) begin
			rx_sync <= 2'b11;
			busy <= 1'b0;
			rx_valid <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
		end
		else begin
			rx_sync <= {rx_sync[0], rx};
			if (rx_valid) begin
				// Line ignored until the byte is taken
				if (rx_take)
					rx_valid <= 1'b0;
			end
			else if (!busy) begin
				if (!rx_sync[1]) begin
					busy <= 1'b1;
					// Half a bit to the middle of the start bit
					div_cnt <= div_half;
					bit_cnt <= '0;
				end
			end
			else if (div_cnt != div_last) begin
				div_cnt <= div_cnt + 1'b1;
			end
			else begin
				div_cnt <= '0;
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == 4'd0) begin
					// Glitch, not a start bit
					if (rx_sync[1])
						busy <= 1'b0;
				end
				else if (bit_cnt <= 4'd8) begin
					shift_reg <= {rx_sync[1], shift_reg[7:1]};
				end
				else begin
					busy <= 1'b0;
					rx_valid <= 1'b1;
				end
			end
		end
	end

endmodule

//--- uart/uart_tx.sv
/*
 * UART transmitter
 * Sends one 8N1 frame per assertion of send, LSB first,
 * busy for the whole frame
 */
`timescale 1ns/1ns
`include "forth_config.svh"

module uart_tx import forth_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  tx_send,
	input  byte_t tx_data,
	output logic  tx,
	output logic  tx_busy
);

	localparam int div_w = $clog2(`UART_BIT_DIV);
	localparam logic [div_w-1:0] div_last = div_w'(`UART_BIT_DIV - 1);

	logic [div_w-1:0] div_cnt;
	logic [3:0] bit_cnt;
	byte_t shift_reg;
	// Frame done, wait for send to drop
	logic sent;

	always_ff @(posedge clk) begin
		if (!reset) begin
			tx <= 1'b1;
			tx_busy <= 1'b0;
			sent <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
		end
		else if (!tx_busy) begin
			div_cnt <= '0;
			bit_cnt <= '0;
			if (!tx_send) begin
				sent <= 1'b0;
			end
			else if (!sent) begin
				// Start bit, byte captured here
				tx_busy <= 1'b1;
				tx <= 1'b0;
				shift_reg <= tx_data;
			end
		end
		else if (div_cnt != div_last) begin
			div_cnt <= div_cnt + 1'b1;
		end
		else begin
			div_cnt <= '0;
			bit_cnt <= bit_cnt + 1'b1;
			if (bit_cnt < 4'd8) begin
				tx <= shift_reg[0];
				shift_reg <= shift_reg >> 1;
			end
			else if (bit_cnt == 4'd8) begin
				tx <= 1'b1;
			end
			else begin
				// End of stop bit
				tx_busy <= 1'b0;
				sent <= 1'b1;
			end
		end
	end

endmodule

//--- verif/forth_patterns.txt
# Columns: command letter, hex value
# S sends a byte on rx, T expects a byte on tx, L expects LEDs {red, blue, green}, low is on
L 7
# red
S 72
S 65
S 64
S 0d
L 3
# green
S 67
S 72
S 65
S 65
S 6e
S 0d
L 6
# blue
S 62
S 6c
S 75
S 65
S 0d
L 5
# 5 .
S 35
S 20
S 2e
S 0d
T 35
T 20
# 3 5 + .
S 33
S 20
S 35
S 20
S 2b
S 20
S 2e
S 0d
T 38
T 20
# 9 3 - .
S 39
S 20
S 33
S 20
S 2d
S 20
S 2e
S 0d
T 36
T 20
# 3 5 - .
S 33
S 20
S 35
S 20
S 2d
S 20
S 2e
S 0d
T 2d
T 32
T 20
# xyz
S 78
S 79
S 7a
S 0d
T 3f
L 5

//--- verif/forth_proc_tb.sv
/*
 * Forth processor testbench
 * Plays the pattern file into the serial input, decodes the serial
 * output and checks transmitted bytes and LED levels
 */
`timescale 1ns/1ns
`include "forth_config.svh"

module forth_proc_tb import forth_pkg::*; ();

	localparam int bit_div = `UART_BIT_DIV;
	// Idle line between sent characters, in bit times
	localparam int gap_bits = 12;
	localparam int settle_cycles = 16 * bit_div;
	localparam int tx_wait_cycles = 60 * bit_div;

	logic clk;
	logic reset;
	logic rx;
	logic tx;
	logic led_r;
	logic led_g;
	logic led_b;

	byte_t cmd_q[$];
	logic [31:0] val_q[$];
	// Bytes decoded from tx, oldest first
	byte_t tx_bytes[$];
	int value_errors = 0;
	int timeout_errors = 0;
	int other_errors = 0;
	int cycles = 0;
	int cycle_limit = 0;

	forth_proc i_dut (
		.clk   (clk),
		.reset (reset),
		.rx    (rx),
		.tx    (tx),
		.led_r (led_r),
		.led_g (led_g),
		.led_b (led_b)
	);

	always #20 clk = ~clk;

	// Run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit != 0 && cycles >= cycle_limit) begin
			$display("Run did not finish within %0d cycles", cycle_limit);
			$display("test failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	task automatic check_byte(input byte_t got, input byte_t exp);
		if (got !== exp) begin
			$display("ERR %0t: tx byte %02h, expected %02h", $time, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_led(input led_t got, input led_t exp);
		if (got !== exp) begin
			$display("ERR %0t: LEDs rbg %03b, expected %03b", $time, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_level(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
			value_errors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Pattern file, one letter and one hex value per line
	task automatic load_patterns(output logic ok);
		int fd;
		int n;
		string line;
		logic [31:0] val;
		fd = $fopen("verif/forth_patterns.txt", "r");
		ok = fd != 0;
		if (ok) begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				// Comment lines start with #
				if (n > 2 && line[0] != "#") begin
					val = '0;
					n = $sscanf(line.substr(2, line.len() - 1), "%h", val);
					cmd_q.push_back(byte_t'(line[0]));
					val_q.push_back(val);
				end
			end
			$fclose(fd);
		end
	endtask

	// 8N1 frame on rx, then an idle gap
	task automatic send_byte(input byte_t data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0};
		@(negedge clk);
		for (int k = 0; k < 10; k++) begin
			rx = frame[k];
			repeat (bit_div) @(negedge clk);
		end
		repeat (gap_bits * bit_div) @(negedge clk);
	endtask

	task automatic expect_tx(input byte_t exp);
		int waited;
		waited = 0;
		while (tx_bytes.size() == 0 && waited < tx_wait_cycles) begin
			@(negedge clk);
			waited++;
		end
		if (tx_bytes.size() == 0) begin
			$display("No byte on tx within %0d cycles, expected %02h", tx_wait_cycles, exp);
			timeout_errors++;
		end
		else begin
			check_byte(tx_bytes.pop_front(), exp);
		end
	endtask

	// Settled means no change for a whole window
	task automatic expect_led(input led_t exp);
		led_t last;
		int stable;
		last = {led_r, led_b, led_g};
		stable = 0;
		while (stable < settle_cycles) begin
			@(negedge clk);
			if ({led_r, led_b, led_g} == last) begin
				stable++;
			end
			else begin
				last = {led_r, led_b, led_g};
				stable = 0;
			end
		end
		check_led(last, exp);
	endtask

	////////////////////////////////////////////////////////////
	// Serial output monitor, sampled mid-bit on the falling edge
	initial begin : tx_monitor
		byte_t b;
		forever begin
			@(negedge clk);
			if (reset && !tx) begin
				// Middle of the start bit
				repeat (bit_div / 2) @(negedge clk);
				for (int k = 0; k < 8; k++) begin
					repeat (bit_div) @(negedge clk);
					b[k] = tx;
				end
				repeat (bit_div) @(negedge clk);
				if (!tx) begin
					$display("ERR %0t: missing stop bit after tx byte %02h", $time, b);
					value_errors++;
				end
				tx_bytes.push_back(b);
			end
		end
	end

	////////////////////////////////////////////////////////////
	initial begin : main
		logic loaded;
		int quiet;
		clk = 1'b0;
		reset = 1'b0;
		rx = 1'b1;
		load_patterns(loaded);
		if (loaded) begin
			// 40 bit times per pattern line at most
			cycle_limit = cmd_q.size() * 40 * bit_div + 100 * bit_div;
			repeat (4) @(posedge clk);
			@(negedge clk);
			reset = 1'b1;
			@(negedge clk);
			check_level(tx, 1'b1, "tx after reset");
			for (int i = 0; i < cmd_q.size(); i++) begin
				case (cmd_q[i])
					"S": send_byte(val_q[i][7:0]);
					"T": expect_tx(val_q[i][7:0]);
					"L": expect_led(val_q[i][2:0]);
					default: begin
						$display("Unknown command letter %c in pattern file", cmd_q[i]);
						other_errors++;
					end
				endcase
			end
			// Line must go quiet, nothing left over
			quiet = 0;
			while (quiet < 20 * bit_div) begin
				@(negedge clk);
				quiet = tx ? quiet + 1 : 0;
			end
			while (tx_bytes.size() != 0) begin
				$display("ERR %0t: unexpected tx byte %02h", $time, tx_bytes.pop_front());
				value_errors++;
			end
		end
		else begin
			$display("Could not open the pattern file verif/forth_patterns.txt");
			other_errors++;
		end
		$display("Errors: %0d wrong values, %0d timeouts, %0d other",
			value_errors, timeout_errors, other_errors);
		if (value_errors == 0 && timeout_errors == 0 && other_errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

//--- verilog/forth_proc.sv
/*
 * Forth processor top level
 * Serial receiver, outer and inner interpreter and serial
 * transmitter, with three active-low LEDs
 */
`timescale 1ns/1ns

module forth_proc import forth_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic rx,
	output logic tx,
	output logic led_r,
	output logic led_g,
	output logic led_b
);

	logic rx_valid;
	byte_t rx_data;
	logic rx_take;
	logic xt_valid;
	rom_addr_t xt_data;
	logic xt_take;
	cell_t num_data;
	logic num_take;
	logic tx_send;
	byte_t tx_data;
	logic tx_busy;
	led_t led;

	// Red, blue, green from MSB down
	assign led_r = led[2];
	assign led_b = led[1];
	assign led_g = led[0];

	uart_rx i_rx (
		.clk      (clk),
		.reset    (reset),
		.rx       (rx),
		.rx_valid (rx_valid),
		.rx_data  (rx_data),
		.rx_take  (rx_take)
	);

	outer_interp i_outer (
		.clk      (clk),
		.reset    (reset),
		.rx_valid (rx_valid),
		.rx_data  (rx_data),
		.rx_take  (rx_take),
		.xt_valid (xt_valid),
		.xt_data  (xt_data),
		.xt_take  (xt_take),
		.num_data (num_data),
		.num_take (num_take)
	);

	inner_interp i_inner (
		.clk      (clk),
		.reset    (reset),
		.xt_valid (xt_valid),
		.xt_data  (xt_data),
		.xt_take  (xt_take),
		.num_data (num_data),
		.num_take (num_take),
		.tx_send  (tx_send),
		.tx_data  (tx_data),
		.tx_busy  (tx_busy),
		.led      (led)
	);

	uart_tx i_tx (
		.clk     (clk),
		.reset   (reset),
		.tx_send (tx_send),
		.tx_data (tx_data),
		.tx      (tx),
		.tx_busy (tx_busy)
	);

endmodule

//--- verilog/inner_interp.sv
/*
 * Forth inner interpreter
 * Fetch/execute unit over a constant boot ROM and a circular data
 * stack. Takes tokens and numbers from the outer interpreter, prints
 * through the UART transmitter and drives the LEDs.
 */
`timescale 1ns/1ns
`include "forth_config.svh"

module inner_interp import forth_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      xt_valid,
	input  rom_addr_t xt_data,
	output logic      xt_take,
	input  cell_t     num_data,
	output logic      num_take,
	output logic      tx_send,
	output byte_t     tx_data,
	input  logic      tx_busy,
	output led_t      led
);

	rom_addr_t pc;
	cell_t ir;
	op_e op;
	cell_t operand;
	rom_addr_t target;
	cell_t dstack [`DSTACK_DEPTH];
	dptr_t dp;
	dptr_t dp_up;
	dptr_t dp_down;
	cell_t tos;
	cell_t nos;
	logic tx_seen_busy;

	////////////////////////////////////////////////////////////
	// Boot program
	function automatic cell_t boot_rom(input rom_addr_t addr);
		case (addr)
			// Wait for the next token
			0:  return cell_t'(op_execute);
			// Error word, prints ?
			1:  return cell_t'(op_lit);
			2:  return cell_t'("?");
			3:  return cell_t'(op_emit);
			4:  return cell_t'(op_branch);
			5:  return cell_t'(0);
			// red
			6:  return cell_t'(op_lit);
			7:  return cell_t'(4);
			8:  return cell_t'(op_io_led);
			9:  return cell_t'(op_branch);
			10: return cell_t'(0);
			// green
			11: return cell_t'(op_lit);
			12: return cell_t'(1);
			13: return cell_t'(op_io_led);
			14: return cell_t'(op_branch);
			15: return cell_t'(0);
			// blue
			16: return cell_t'(op_lit);
			17: return cell_t'(2);
			18: return cell_t'(op_io_led);
			19: return cell_t'(op_branch);
			20: return cell_t'(0);
			// Push a queued digit
			21: return cell_t'(op_number);
			22: return cell_t'(op_branch);
			23: return cell_t'(0);
			// . signed digit and a space
			24: return cell_t'(op_dup);
			25: return cell_t'(op_zero_less_than);
			26: return cell_t'(op_0branch);
			27: return cell_t'(32);
			28: return cell_t'(op_lit);
			29: return cell_t'("-");
			30: return cell_t'(op_emit);
			31: return cell_t'(op_negate);
			32: return cell_t'(op_lit);
			33: return cell_t'("0");
			34: return cell_t'(op_plus);
			35: return cell_t'(op_emit);
			36: return cell_t'(op_lit);
			37: return cell_t'(" ");
			38: return cell_t'(op_emit);
			39: return cell_t'(op_branch);
			40: return cell_t'(0);
			// + and -
			41: return cell_t'(op_plus);
			42: return cell_t'(op_branch);
			43: return cell_t'(0);
			44: return cell_t'(op_minus);
			45: return cell_t'(op_branch);
			46: return cell_t'(0);
			default: return cell_t'(op_execute);
		endcase
	endfunction

	assign ir = boot_rom(pc);
	assign op = op_e'(ir[3:0]);
	// Inline cell after lit, branch and 0branch
	assign operand = boot_rom(pc + 1'b1);
	assign target = operand[$bits(rom_addr_t)-1:0];
	assign dp_up = dp + 1'b1;
	assign dp_down = dp - 1'b1;
	assign tos = dstack[dp];
	assign nos = dstack[dp_down];

	// Pops happen in the same cycle as the request
	assign xt_take = op == op_execute && xt_valid;
	assign num_take = op == op_number;

	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!reset) begin
			pc <= '0;
			dp <= '0;
			tx_send <= 1'b0;
			tx_seen_busy <= 1'b0;
			led <= '1;
		end
		else begin
			pc <= pc + 1'b1;
			case (op)
				op_lit: begin
					dstack[dp_up] <= operand;
					dp <= dp_up;
					pc <= pc + 2'd2;
				end
				op_branch: pc <= target;
				op_0branch: begin
					dp <= dp_down;
					pc <= (tos == '0) ? target : pc + 2'd2;
				end
				op_dup: begin
					dstack[dp_up] <= tos;
					dp <= dp_up;
				end
				op_drop: dp <= dp_down;
				op_plus: begin
					dstack[dp_down] <= nos + tos;
					dp <= dp_down;
				end
				op_minus: begin
					dstack[dp_down] <= nos - tos;
					dp <= dp_down;
				end
				op_negate: dstack[dp] <= -tos;
				op_zero_equal: dstack[dp] <= (tos == '0) ? '1 : '0;
				op_zero_less_than: dstack[dp] <= tos[`CELL_WIDTH-1] ? '1 : '0;
				op_emit: begin
					// Hold here for the whole frame
					pc <= pc;
					if (!tx_send) begin
						tx_send <= 1'b1;
						tx_data <= tos[7:0];
						dp <= dp_down;
					end
					else if (tx_busy) begin
						tx_seen_busy <= 1'b1;
					end
					else if (tx_seen_busy) begin
						tx_send <= 1'b0;
						tx_seen_busy <= 1'b0;
						pc <= pc + 1'b1;
					end
				end
				op_io_led: begin
					// Set bit lights the LED, outputs are active low
					led <= ~tos[2:0];
					dp <= dp_down;
				end
				op_execute: pc <= xt_valid ? xt_data : pc;
				op_number: begin
					dstack[dp_up] <= num_data;
					dp <= dp_up;
				end
				default: ;
			endcase
		end
	end

endmodule

//--- verilog/outer_interp.sv
/*
 * Forth outer interpreter
 * Packs incoming characters into counted-name cells, walks a constant
 * linked dictionary at each word end and queues the found token.
 * Single digits go to the number queue. End of line starts the
 * execute phase, which lasts until the token queue is drained.
 */
`timescale 1ns/1ns
`include "forth_config.svh"

module outer_interp import forth_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      rx_valid,
	input  byte_t     rx_data,
	output logic      rx_take,
	output logic      xt_valid,
	output rom_addr_t xt_data,
	input  logic      xt_take,
	output cell_t     num_data,
	input  logic      num_take
);

	localparam int dict_aw = $clog2(`DICT_DEPTH);
	localparam int queue_aw = $clog2(`QUEUE_DEPTH);
	// Entry points of the number and error words in the boot ROM
	localparam rom_addr_t xt_number = 21;
	localparam rom_addr_t xt_error = 1;

	typedef enum logic [2:0] {
		st_idle, st_parse, st_get_link, st_search, st_get_token, st_number, st_execute
	} state_e;

	state_e state;
	cell_t word_buf [4];
	logic [3:0] char_cnt;
	logic [3:0] char_next;
	logic [2:0] word_cells;
	logic [2:0] cell_idx;
	logic [dict_aw-1:0] wp;
	logic [dict_aw-1:0] link_addr;
	cell_t dict_q;
	logic line_end;
	logic is_digit;
	rom_addr_t new_xt;
	rom_addr_t xt_queue [`QUEUE_DEPTH];
	cell_t num_queue [`QUEUE_DEPTH];
	logic [queue_aw-1:0] xt_rd;
	logic [queue_aw-1:0] xt_wr;
	logic [queue_aw-1:0] num_rd;
	logic [queue_aw-1:0] num_wr;

	////////////////////////////////////////////////////////////
	// Dictionary: link, counted name cells, token
	function automatic cell_t dict_cell(input logic [dict_aw-1:0] addr);
		case (addr)
			0:  return cell_t'(3);
			1:  return {8'd1, "red"};
			2:  return cell_t'(6);
			3:  return cell_t'(7);
			4:  return {8'd2, "gre"};
			5:  return {"en", 16'd0};
			6:  return cell_t'(11);
			7:  return cell_t'(11);
			8:  return {8'd2, "blu"};
			9:  return {"e", 24'd0};
			10: return cell_t'(16);
			11: return cell_t'(14);
			12: return {8'd1, ".", 16'd0};
			13: return cell_t'(24);
			14: return cell_t'(17);
			15: return {8'd1, "+", 16'd0};
			16: return cell_t'(41);
			// Last entry, link 0 ends the chain
			17: return cell_t'(0);
			18: return {8'd1, "-", 16'd0};
			19: return cell_t'(44);
			default: return '0;
		endcase
	endfunction

	assign dict_q = dict_cell(wp);
	assign char_next = char_cnt + 4'd1;
	assign word_cells = {1'b0, char_cnt[3:2]} + 3'd1;
	// rx_data stays put until rx_take
	assign line_end = rx_data >= 8'd10 && rx_data <= 8'd13;
	assign is_digit = char_cnt == 4'd1 && word_buf[0][23:16] >= "0"
		&& word_buf[0][23:16] <= "9";
	assign new_xt = (state == st_get_token) ? dict_q[$bits(rom_addr_t)-1:0]
		: (is_digit ? xt_number : xt_error);

	assign xt_valid = state == st_execute && xt_rd != xt_wr;
	assign xt_data = xt_queue[xt_rd];
	assign num_data = num_queue[num_rd];

	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= st_idle;
			rx_take <= 1'b0;
			char_cnt <= '0;
			word_buf <= '{default: '0};
			wp <= '0;
			link_addr <= '0;
			cell_idx <= '0;
			xt_rd <= '0;
			xt_wr <= '0;
			num_rd <= '0;
			num_wr <= '0;
		end
		else begin
			rx_take <= 1'b0;
			if (xt_take)
				xt_rd <= xt_rd + 1'b1;
			if (num_take)
				num_rd <= num_rd + 1'b1;
			case (state)
				st_idle: begin
					// Skip the cycle in which the last byte is still being taken
					if (rx_valid && !rx_take)
						state <= st_parse;
				end
				st_parse: begin
					wp <= '0;
					if (line_end || rx_data == " ") begin
						if (char_cnt != 4'd0) begin
							state <= st_get_link;
						end
						else if (line_end) begin
							state <= st_execute;
						end
						else begin
							state <= st_idle;
							rx_take <= 1'b1;
						end
					end
					else begin
						// Big-endian after the count byte, long words clipped
						if (char_cnt != 4'd15) begin
							char_cnt <= char_next;
							word_buf[char_next[3:2]][(3 - char_next[1:0]) * 8 +: 8] <= rx_data;
							word_buf[0][31:24] <= {6'd0, char_next[3:2]} + 8'd1;
						end
						state <= st_idle;
						rx_take <= 1'b1;
					end
				end
				st_get_link: begin
					link_addr <= dict_q[dict_aw-1:0];
					wp <= wp + 1'b1;
					cell_idx <= '0;
					state <= st_search;
				end
				st_search: begin
					if (cell_idx == word_cells) begin
						state <= st_get_token;
					end
					else if (dict_q == word_buf[cell_idx[1:0]]) begin
						wp <= wp + 1'b1;
						cell_idx <= cell_idx + 3'd1;
					end
					else if (link_addr != '0) begin
						wp <= link_addr;
						state <= st_get_link;
					end
					else begin
						state <= st_number;
					end
				end
				st_get_token, st_number: begin
					// Word end, queue the token and clear the buffer
					if (state == st_number && is_digit) begin
						num_queue[num_wr] <= cell_t'(word_buf[0][23:16] - "0");
						num_wr <= num_wr + 1'b1;
					end
					xt_queue[xt_wr] <= new_xt;
					xt_wr <= xt_wr + 1'b1;
					char_cnt <= '0;
					word_buf <= '{default: '0};
					state <= line_end ? st_execute : st_idle;
					rx_take <= !line_end;
				end
				st_execute: begin
					if (xt_rd == xt_wr) begin
						state <= st_idle;
						rx_take <= 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule
